//--- hdl/axi_log_macros.svh
`ifndef AXI_LOG_MACROS_SVH
`define AXI_LOG_MACROS_SVH

// AXI master port widths
`define AXI_ADDR_W   32
`define AXI_DATA_W   64
`define AXI_STRB_W   8

// History depth and index width
`define LOG_DEPTH    8
`define LOG_IDX_W    3

// Address record is padded up to the log record width
`define ADDR_REC_W   53
`define LOG_REC_W    73
`define ADDR_PAD_W   (`LOG_REC_W - `ADDR_REC_W)

// Fixed read data returned by the stub target
`define READ_PATTERN 64'h0000_1234_5678_0000

// AXI response codes
`define RESP_OKAY    2'b00

`endif

//--- hdl/axi_log_pkg.sv
`default_nettype none

`include "axi_log_macros.svh"

package axi_log_pkg;

    //////////////////////////////////////////////////
    // AXI channel groups
    //////////////////////////////////////////////////

    // Shared by AW and AR
    typedef struct packed {
        logic                    valid;
        logic [`AXI_ADDR_W-1:0]  addr;
        logic [7:0]              len;
        logic [2:0]              size;
        logic [1:0]              burst;
        logic [2:0]              prot;
        logic                    lock;
        logic [3:0]              cache;
    } axi_addr_req_t;

    typedef struct packed {
        logic                    valid;
        logic [`AXI_DATA_W-1:0]  data;
        logic [`AXI_STRB_W-1:0]  strb;
        logic                    last;
    } axi_wdata_req_t;

    typedef struct packed {
        logic                    valid;
        logic [`AXI_DATA_W-1:0]  data;
        logic [1:0]              resp;
        logic                    last;
    } axi_rdata_rsp_t;

    typedef struct packed {
        logic                    valid;
        logic [1:0]              resp;
    } axi_bresp_rsp_t;

    //////////////////////////////////////////////////
    // Log records
    //////////////////////////////////////////////////

    // Low ADDR_REC_W bits are what the history keeps
    typedef struct packed {
        logic [`ADDR_PAD_W-1:0]  pad;
        logic [`AXI_ADDR_W-1:0]  addr;
        logic [7:0]              len;
        logic [2:0]              size;
        logic [1:0]              burst;
        logic [2:0]              prot;
        logic                    lock;
        logic [3:0]              cache;
    } addr_rec_t;

    typedef struct packed {
        logic [`AXI_DATA_W-1:0]  data;
        logic [`AXI_STRB_W-1:0]  strb;
        logic                    last;
    } wdata_rec_t;

    // Readout word decoded by the selected channel
    typedef union packed {
        addr_rec_t               arec;
        wdata_rec_t              wrec;
    } log_word_u;

    typedef enum logic [1:0] {
        LOG_AW = 2'd0,
        LOG_AR = 2'd1,
        LOG_W  = 2'd2
    } log_chan_e;

endpackage

`default_nettype wire

//--- hdl/axi_stub_target.sv
`default_nettype none

`include "axi_log_macros.svh"

module axi_stub_target
    import axi_log_pkg::*;
(
    input  wire              axi_clk,
    input  wire              i_rst_n,

    // Requests from the bridge master port
    input  axi_addr_req_t    i_aw,
    input  axi_addr_req_t    i_ar,
    input  axi_wdata_req_t   i_w,
    input  wire              i_rready,
    input  wire              i_bready,

    output logic             o_awready,
    output logic             o_arready,
    output logic             o_wready,
    output axi_rdata_rsp_t   o_r,
    output axi_bresp_rsp_t   o_b,

    // One cycle per accepted beat
    output logic             o_aw_fire,
    output logic             o_ar_fire,
    output logic             o_w_fire
);

    logic r_valid;
    logic b_valid;
    logic wr_accept;

    //////////////////////////////////////////////////
    // Read path
    //////////////////////////////////////////////////

    // Only one read in flight
    assign o_arready = !r_valid;
    assign o_ar_fire = i_ar.valid && o_arready;

    always_ff @(posedge axi_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_valid <= 1'b0;
        end else if (r_valid && i_rready) begin
            r_valid <= 1'b0;
        end else if (o_ar_fire) begin
            r_valid <= 1'b1;
        end
    end

    // Every read gets the same single beat
    assign o_r.valid = r_valid;
    assign o_r.data  = `READ_PATTERN;
    assign o_r.resp  = `RESP_OKAY;
    assign o_r.last  = 1'b1;

    //////////////////////////////////////////////////
    // Write path
    //////////////////////////////////////////////////

    // AW and W must show up in the same cycle
    assign wr_accept = i_aw.valid && i_w.valid && !b_valid;

    assign o_awready = wr_accept;
    assign o_wready  = wr_accept;
    assign o_aw_fire = wr_accept;
    assign o_w_fire  = wr_accept;

    always_ff @(posedge axi_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            b_valid <= 1'b0;
        end else if (b_valid && i_bready) begin
            b_valid <= 1'b0;
        end else if (wr_accept) begin
            b_valid <= 1'b1;
        end
    end

    assign o_b.valid = b_valid;
    assign o_b.resp  = `RESP_OKAY;

endmodule

`default_nettype wire

//--- hdl/txn_history.sv
`default_nettype none

`include "axi_log_macros.svh"

module txn_history #(
    parameter int REC_W = `LOG_REC_W
) (
    input  wire                   axi_clk,
    input  wire                   i_rst_n,

    input  wire                   i_push,
    input  wire [REC_W-1:0]       i_rec,

    input  wire [`LOG_IDX_W-1:0]  i_idx,
    output logic [REC_W-1:0]      o_rec
);

    // Entry 0 holds the newest record
    logic [`LOG_DEPTH-1:0][REC_W-1:0] hist;

    always_ff @(posedge axi_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            hist <= '0;
        end else if (i_push) begin
            // Oldest entry falls off the top
            hist <= {hist[`LOG_DEPTH-2:0], i_rec};
        end
    end

    assign o_rec = hist[i_idx];

endmodule

`default_nettype wire

//--- hdl/txn_monitor.sv
`default_nettype none

`include "axi_log_macros.svh"

module txn_monitor
    import axi_log_pkg::*;
(
    input  wire                   axi_clk,
    input  wire                   i_rst_n,

    // Request channels as seen on the bus
    input  axi_addr_req_t         i_aw,
    input  axi_addr_req_t         i_ar,
    input  axi_wdata_req_t        i_w,

    // Accept strobes from the target
    input  wire                   i_aw_fire,
    input  wire                   i_ar_fire,
    input  wire                   i_w_fire,

    // Log readout
    input  log_chan_e             i_log_sel,
    input  wire [`LOG_IDX_W-1:0]  i_log_idx,
    output log_word_u             o_log_word
);

    addr_rec_t                aw_rec;
    addr_rec_t                ar_rec;
    wdata_rec_t               w_rec;

    logic [`ADDR_REC_W-1:0]   aw_out;
    logic [`ADDR_REC_W-1:0]   ar_out;
    logic [`LOG_REC_W-1:0]    w_out;

    addr_rec_t                aw_view;
    addr_rec_t                ar_view;

    // Drops valid and keeps the pad at zero
    function automatic addr_rec_t to_addr_rec(input axi_addr_req_t req);
        addr_rec_t rec;
        rec       = '0;
        rec.addr  = req.addr;
        rec.len   = req.len;
        rec.size  = req.size;
        rec.burst = req.burst;
        rec.prot  = req.prot;
        rec.lock  = req.lock;
        rec.cache = req.cache;
        return rec;
    endfunction

    assign aw_rec = to_addr_rec(i_aw);
    assign ar_rec = to_addr_rec(i_ar);

    assign w_rec.data = i_w.data;
    assign w_rec.strb = i_w.strb;
    assign w_rec.last = i_w.last;

    //////////////////////////////////////////////////
    // Channel histories
    //////////////////////////////////////////////////

    txn_history #(.REC_W(`ADDR_REC_W)) aw_hist (
        .axi_clk (axi_clk),
        .i_rst_n (i_rst_n),
        .i_push  (i_aw_fire),
        .i_rec   (aw_rec[`ADDR_REC_W-1:0]),
        .i_idx   (i_log_idx),
        .o_rec   (aw_out)
    );

    txn_history #(.REC_W(`ADDR_REC_W)) ar_hist (
        .axi_clk (axi_clk),
        .i_rst_n (i_rst_n),
        .i_push  (i_ar_fire),
        .i_rec   (ar_rec[`ADDR_REC_W-1:0]),
        .i_idx   (i_log_idx),
        .o_rec   (ar_out)
    );

    txn_history #(.REC_W(`LOG_REC_W)) w_hist (
        .axi_clk (axi_clk),
        .i_rst_n (i_rst_n),
        .i_push  (i_w_fire),
        .i_rec   (w_rec),
        .i_idx   (i_log_idx),
        .o_rec   (w_out)
    );

    // Restore the zero pad in front of the stored fields
    assign aw_view = {{`ADDR_PAD_W{1'b0}}, aw_out};
    assign ar_view = {{`ADDR_PAD_W{1'b0}}, ar_out};

    always_comb begin
        o_log_word = '0;
        case (i_log_sel)
            LOG_AW:  o_log_word.arec = aw_view;
            LOG_AR:  o_log_word.arec = ar_view;
            LOG_W:   o_log_word.wrec = w_out;
            default: o_log_word = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/axi_log_top.sv
`default_nettype none

`include "axi_log_macros.svh"

module axi_log_top
    import axi_log_pkg::*;
(
    input  wire                   axi_clk,
    input  wire                   i_rst_n,

    // AXI master port of the bridge
    input  axi_addr_req_t         i_aw,
    input  axi_addr_req_t         i_ar,
    input  axi_wdata_req_t        i_w,
    input  wire                   i_rready,
    input  wire                   i_bready,

    output logic                  o_awready,
    output logic                  o_arready,
    output logic                  o_wready,
    output axi_rdata_rsp_t        o_r,
    output axi_bresp_rsp_t        o_b,

    // Transaction log readout
    input  log_chan_e             i_log_sel,
    input  wire [`LOG_IDX_W-1:0]  i_log_idx,
    output log_word_u             o_log_word
);

    logic aw_fire;
    logic ar_fire;
    logic w_fire;

    //////////////////////////////////////////////////
    // Stub target
    //////////////////////////////////////////////////

    axi_stub_target u_target (
        .axi_clk   (axi_clk),
        .i_rst_n   (i_rst_n),
        .i_aw      (i_aw),
        .i_ar      (i_ar),
        .i_w       (i_w),
        .i_rready  (i_rready),
        .i_bready  (i_bready),
        .o_awready (o_awready),
        .o_arready (o_arready),
        .o_wready  (o_wready),
        .o_r       (o_r),
        .o_b       (o_b),
        .o_aw_fire (aw_fire),
        .o_ar_fire (ar_fire),
        .o_w_fire  (w_fire)
    );

    //////////////////////////////////////////////////
    // Transaction monitor
    //////////////////////////////////////////////////

    // Samples the same request buses the target sees
    txn_monitor u_monitor (
        .axi_clk    (axi_clk),
        .i_rst_n    (i_rst_n),
        .i_aw       (i_aw),
        .i_ar       (i_ar),
        .i_w        (i_w),
        .i_aw_fire  (aw_fire),
        .i_ar_fire  (ar_fire),
        .i_w_fire   (w_fire),
        .i_log_sel  (i_log_sel),
        .i_log_idx  (i_log_idx),
        .o_log_word (o_log_word)
    );

endmodule

`default_nettype wire

//--- test/tb_axi_log_top.sv
`default_nettype none

`include "axi_log_macros.svh"

module tb_axi_log_top
    import axi_log_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    // Roughly four times the length of all tests
    localparam int CYCLE_LIMIT = 2000;

    logic                   axi_clk = 1'b0;
    logic                   i_rst_n;
    axi_addr_req_t          aw_req;
    axi_addr_req_t          ar_req;
    axi_wdata_req_t         w_req;
    logic                   rready;
    logic                   bready;
    log_chan_e              log_sel;
    logic [`LOG_IDX_W-1:0]  log_idx;

    logic                   awready;
    logic                   arready;
    logic                   wready;
    axi_rdata_rsp_t         r_rsp;
    axi_bresp_rsp_t         b_rsp;
    log_word_u              log_word;

    integer                 seed = 32'h1751;
    int                     cycle_count = 0;
    int                     error_count = 0;

    // Newest record at the front
    addr_rec_t              aw_model[$];
    addr_rec_t              ar_model[$];
    wdata_rec_t             w_model[$];

    axi_rdata_rsp_t         r_expected;
    axi_bresp_rsp_t         b_expected;

    axi_log_top UUT (
        .axi_clk    (axi_clk),
        .i_rst_n    (i_rst_n),
        .i_aw       (aw_req),
        .i_ar       (ar_req),
        .i_w        (w_req),
        .i_rready   (rready),
        .i_bready   (bready),
        .o_awready  (awready),
        .o_arready  (arready),
        .o_wready   (wready),
        .o_r        (r_rsp),
        .o_b        (b_rsp),
        .i_log_sel  (log_sel),
        .i_log_idx  (log_idx),
        .o_log_word (log_word)
    );

    always #2 axi_clk = ~axi_clk;

    always @(posedge axi_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
            $display("Test failures found");
            $fatal(1, "Simulation stopped on timeout");
        end
    end

    //////////////////////////////////////////////////
    // Checking
    //////////////////////////////////////////////////

    task automatic report_failure(input string msg);
        error_count++;
        $display("FAILED at time %0t: %s", $time, msg);
        $display("Test failures found");
        $fatal(1, "Stopping at the first error");
    endtask

    task automatic compare_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            report_failure($sformatf("%s: got %b, expected %b", what, got, exp));
        end
    endtask

    task automatic compare_rdata(input axi_rdata_rsp_t got, input axi_rdata_rsp_t exp,
                                 input string what);
        if (got !== exp) begin
            report_failure($sformatf("%s: got %h, expected %h", what, got, exp));
        end
    endtask

    task automatic compare_bresp(input axi_bresp_rsp_t got, input axi_bresp_rsp_t exp,
                                 input string what);
        if (got !== exp) begin
            report_failure($sformatf("%s: got %h, expected %h", what, got, exp));
        end
    endtask

    task automatic compare_addr_rec(input addr_rec_t got, input addr_rec_t exp,
                                    input string what);
        if (got !== exp) begin
            report_failure($sformatf("%s: got %h, expected %h", what, got, exp));
        end
    endtask

    task automatic compare_wdata_rec(input wdata_rec_t got, input wdata_rec_t exp,
                                     input string what);
        if (got !== exp) begin
            report_failure($sformatf("%s: got %h, expected %h", what, got, exp));
        end
    endtask

    //////////////////////////////////////////////////
    // Stimulus helpers
    //////////////////////////////////////////////////

    function automatic addr_rec_t random_addr_rec();
        addr_rec_t   rec;
        logic [31:0] r0;
        logic [31:0] r1;
        r0 = $random(seed);
        r1 = $random(seed);
        rec = '0;
        rec.addr  = r0;
        rec.len   = r1[7:0];
        rec.size  = r1[10:8];
        rec.burst = r1[12:11];
        rec.prot  = r1[15:13];
        rec.lock  = r1[16];
        rec.cache = r1[20:17];
        return rec;
    endfunction

    function automatic wdata_rec_t random_wdata_rec();
        wdata_rec_t  rec;
        logic [31:0] r0;
        logic [31:0] r1;
        logic [31:0] r2;
        r0 = $random(seed);
        r1 = $random(seed);
        r2 = $random(seed);
        rec.data = {r0, r1};
        rec.strb = r2[7:0];
        rec.last = r2[8];
        return rec;
    endfunction

    // Request beat carrying the fields of a record
    function automatic axi_addr_req_t make_addr_req(input addr_rec_t rec);
        axi_addr_req_t req;
        req.valid = 1'b1;
        req.addr  = rec.addr;
        req.len   = rec.len;
        req.size  = rec.size;
        req.burst = rec.burst;
        req.prot  = rec.prot;
        req.lock  = rec.lock;
        req.cache = rec.cache;
        return req;
    endfunction

    function automatic axi_wdata_req_t make_wdata_req(input wdata_rec_t rec);
        axi_wdata_req_t req;
        req.valid = 1'b1;
        req.data  = rec.data;
        req.strb  = rec.strb;
        req.last  = rec.last;
        return req;
    endfunction

    task automatic wait_arready();
        @(negedge axi_clk);
        while (arready !== 1'b1) @(negedge axi_clk);
    endtask

    task automatic wait_write_ready();
        @(negedge axi_clk);
        while ((awready & wready) !== 1'b1) @(negedge axi_clk);
    endtask

    task automatic issue_ar(input addr_rec_t rec);
        @(posedge axi_clk);
        ar_req <= make_addr_req(rec);
        wait_arready();
        // Handshake completes on this edge
        @(posedge axi_clk);
        ar_req <= '0;
        ar_model.push_front(rec);
    endtask

    task automatic issue_write(input addr_rec_t aw_rec, input wdata_rec_t w_rec);
        @(posedge axi_clk);
        aw_req <= make_addr_req(aw_rec);
        w_req  <= make_wdata_req(w_rec);
        wait_write_ready();
        @(posedge axi_clk);
        aw_req <= '0;
        w_req  <= '0;
        aw_model.push_front(aw_rec);
        w_model.push_front(w_rec);
    endtask

    task automatic finish_read();
        @(negedge axi_clk);
        compare_rdata(r_rsp, r_expected, "read response");
        compare_bit(arready, 1'b0, "arready while read pending");
        @(posedge axi_clk);
        rready <= 1'b1;
        @(posedge axi_clk);
        rready <= 1'b0;
        @(negedge axi_clk);
        compare_bit(r_rsp.valid, 1'b0, "R valid after rready");
    endtask

    task automatic finish_write();
        @(negedge axi_clk);
        compare_bresp(b_rsp, b_expected, "write response");
        @(posedge axi_clk);
        bready <= 1'b1;
        @(posedge axi_clk);
        bready <= 1'b0;
        @(negedge axi_clk);
        compare_bit(b_rsp.valid, 1'b0, "B valid after bready");
    endtask

    task automatic read_log(input log_chan_e sel, input int idx, output log_word_u word);
        @(posedge axi_clk);
        log_sel <= sel;
        log_idx <= idx[`LOG_IDX_W-1:0];
        @(negedge axi_clk);
        word = log_word;
    endtask

    //////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////

    task automatic test_reset_state();
        log_word_u word;
        @(negedge axi_clk);
        compare_bit(r_rsp.valid, 1'b0, "R valid after reset");
        compare_bit(b_rsp.valid, 1'b0, "B valid after reset");
        compare_bit(arready, 1'b1, "arready after reset");
        for (int i = 0; i < `LOG_DEPTH; i++) begin
            read_log(LOG_AW, i, word);
            compare_addr_rec(word.arec, '0, $sformatf("AW entry %0d after reset", i));
            read_log(LOG_AR, i, word);
            compare_addr_rec(word.arec, '0, $sformatf("AR entry %0d after reset", i));
            read_log(LOG_W, i, word);
            compare_wdata_rec(word.wrec, '0, $sformatf("W entry %0d after reset", i));
        end
    endtask

    task automatic test_read();
        addr_rec_t rec_a;
        addr_rec_t rec_b;
        rec_a = '0;
        rec_a.addr  = 32'h0000_1000;
        rec_a.size  = 3'd3;
        rec_a.burst = 2'b01;
        rec_b = random_addr_rec();
        issue_ar(rec_a);
        @(negedge axi_clk);
        compare_rdata(r_rsp, r_expected, "first read response");
        // Second AR must wait for the pending response
        @(posedge axi_clk);
        ar_req <= make_addr_req(rec_b);
        repeat (3) begin
            @(negedge axi_clk);
            compare_bit(arready, 1'b0, "arready with read pending");
            compare_bit(r_rsp.valid, 1'b1, "R valid held without rready");
        end
        @(posedge axi_clk);
        rready <= 1'b1;
        @(posedge axi_clk);
        rready <= 1'b0;
        wait_arready();
        compare_bit(r_rsp.valid, 1'b0, "R valid after first response");
        @(posedge axi_clk);
        ar_req <= '0;
        ar_model.push_front(rec_b);
        finish_read();
    endtask

    task automatic test_write();
        issue_write(random_addr_rec(), random_wdata_rec());
        finish_write();
        // AW without W is never accepted
        @(posedge axi_clk);
        aw_req <= make_addr_req(random_addr_rec());
        repeat (4) begin
            @(negedge axi_clk);
            compare_bit(awready, 1'b0, "awready with AW alone");
            compare_bit(wready, 1'b0, "wready with AW alone");
            compare_bit(b_rsp.valid, 1'b0, "B valid with AW alone");
        end
        @(posedge axi_clk);
        aw_req <= '0;
    endtask

    task automatic test_backpressure();
        addr_rec_t  ar_rec;
        addr_rec_t  aw_rec;
        wdata_rec_t w_rec;
        ar_rec = random_addr_rec();
        aw_rec = random_addr_rec();
        w_rec  = random_wdata_rec();
        issue_ar(random_addr_rec());
        issue_write(random_addr_rec(), random_wdata_rec());
        @(posedge axi_clk);
        ar_req <= make_addr_req(ar_rec);
        aw_req <= make_addr_req(aw_rec);
        w_req  <= make_wdata_req(w_rec);
        repeat (6) begin
            @(negedge axi_clk);
            compare_rdata(r_rsp, r_expected, "R held under back-pressure");
            compare_bresp(b_rsp, b_expected, "B held under back-pressure");
            compare_bit(arready, 1'b0, "arready under back-pressure");
            compare_bit(awready, 1'b0, "awready under back-pressure");
            compare_bit(wready, 1'b0, "wready under back-pressure");
        end
        @(posedge axi_clk);
        rready <= 1'b1;
        bready <= 1'b1;
        @(posedge axi_clk);
        rready <= 1'b0;
        bready <= 1'b0;
        @(negedge axi_clk);
        compare_bit(arready, 1'b1, "arready after release");
        compare_bit(awready, 1'b1, "awready after release");
        compare_bit(wready, 1'b1, "wready after release");
        @(posedge axi_clk);
        ar_req <= '0;
        aw_req <= '0;
        w_req  <= '0;
        ar_model.push_front(ar_rec);
        aw_model.push_front(aw_rec);
        w_model.push_front(w_rec);
        finish_read();
        finish_write();
    endtask

    task automatic test_history();
        log_word_u word;
        for (int n = 0; n < 12; n++) begin
            issue_write(random_addr_rec(), random_wdata_rec());
            finish_write();
            issue_ar(random_addr_rec());
            finish_read();
        end
        for (int i = 0; i < `LOG_DEPTH; i++) begin
            read_log(LOG_AW, i, word);
            compare_addr_rec(word.arec, aw_model[i], $sformatf("AW history entry %0d", i));
            read_log(LOG_AR, i, word);
            compare_addr_rec(word.arec, ar_model[i], $sformatf("AR history entry %0d", i));
            read_log(LOG_W, i, word);
            compare_wdata_rec(word.wrec, w_model[i], $sformatf("W history entry %0d", i));
        end
    endtask

    initial begin
        i_rst_n = 1'b0;
        aw_req  = '0;
        ar_req  = '0;
        w_req   = '0;
        rready  = 1'b0;
        bready  = 1'b0;
        log_sel = LOG_AW;
        log_idx = '0;
        r_expected.valid = 1'b1;
        r_expected.data  = `READ_PATTERN;
        r_expected.resp  = `RESP_OKAY;
        r_expected.last  = 1'b1;
        b_expected.valid = 1'b1;
        b_expected.resp  = `RESP_OKAY;
        repeat (5) @(posedge axi_clk);
        i_rst_n <= 1'b1;
        test_reset_state();
        test_read();
        test_write();
        test_backpressure();
        test_history();
        if (error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
+incdir+hdl
hdl/axi_log_pkg.sv
hdl/axi_stub_target.sv
hdl/txn_history.sv
hdl/txn_monitor.sv
hdl/axi_log_top.sv
test/tb_axi_log_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timescale 1ns/1ps -f all.f --top-module tb_axi_log_top \
    > "$BUILD_LOG" 2>&1 \
    || { cat "$BUILD_LOG"; echo "Verilator build failed"; exit 1; }

./obj_dir/Vtb_axi_log_top > "$SIM_LOG" 2>&1
cat "$SIM_LOG"

grep -q "All tests passed!" "$SIM_LOG" \
    && echo "Simulation PASSED" \
    || { echo "Simulation FAILED"; exit 1; }
